// ==== project.f ====
mmu_pkg.sv
mmu_ifs.sv
dtlb.sv
ptw.sv
xlate_check.sv
mmu_ctrl.sv
mmu_top.sv
tb_mmu_top.sv

// ==== Makefile ====
# Verilator build and run of the Sv39 data MMU testbench
TOP := tb_mmu_top
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "\*\*\* TEST FAILED \*\*\*" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_mmu_top.sv ====
/*
 * random testbench for the Sv39 data MMU: page table memory with a four-phase
 * port, reference translation model, bare mode, permission, walk fault and flush cases
 */
`timescale 1ns/10ps
`default_nettype none

module tb_mmu_top;

  localparam int unsigned SEED        = 32'hf2f6_2df0;
  localparam int          ACK_TIMEOUT = 200;
  localparam int          NUM_RANDOM  = 12;
  // req set on a falling edge, ack two rising edges after the first one
  localparam int          HIT_LATENCY = 3;
  localparam logic [9:0]  F_V = 10'd1 << mmu_pkg::PTE_V;
  localparam logic [9:0]  F_R = 10'd1 << mmu_pkg::PTE_R;
  localparam logic [9:0]  F_W = 10'd1 << mmu_pkg::PTE_W;
  localparam logic [9:0]  F_X = 10'd1 << mmu_pkg::PTE_X;
  localparam logic [9:0]  F_U = 10'd1 << mmu_pkg::PTE_U;
  localparam logic [9:0]  F_A = 10'd1 << mmu_pkg::PTE_A;
  localparam logic [9:0]  F_D = 10'd1 << mmu_pkg::PTE_D;

  bit                clk;
  logic              rst_n_i;
  logic              lsu_req_i;
  mmu_pkg::vaddr_t   lsu_vaddr_i;
  logic              lsu_is_store_i;
  logic              lsu_ack_o;
  mmu_pkg::paddr_t   lsu_paddr_o;
  logic              lsu_exc_valid_o;
  mmu_pkg::cause_t   lsu_exc_cause_o;
  mmu_pkg::vaddr_t   lsu_exc_tval_o;
  logic              mem_req_o;
  mmu_pkg::paddr_t   mem_addr_o;
  logic              mem_ack_i;
  mmu_pkg::pte_t     mem_rdata_i;
  logic              en_translation_i;
  logic              priv_user_i;
  logic              sum_i;
  logic              mxr_i;
  mmu_pkg::ppn_t     satp_ppn_i;
  logic              flush_tlb_i;

  // page table memory, a missing address reads as an invalid pte
  mmu_pkg::pte_t     pt_mem [mmu_pkg::paddr_t];
  mmu_pkg::ppn_t     next_table;
  logic [8:0]        next_vpn2;
  int unsigned       mem_delay;
  int                errors;
  int                timeouts;

  // last transaction as seen by the lsu
  mmu_pkg::paddr_t   res_paddr;
  logic              res_exc;
  mmu_pkg::cause_t   res_cause;
  mmu_pkg::vaddr_t   res_tval;
  logic              res_mem;
  int                res_lat;

  mmu_top u_dut (
    .clk_i            (clk),
    .rst_n_i          (rst_n_i),
    .lsu_req_i        (lsu_req_i),
    .lsu_vaddr_i      (lsu_vaddr_i),
    .lsu_is_store_i   (lsu_is_store_i),
    .lsu_ack_o        (lsu_ack_o),
    .lsu_paddr_o      (lsu_paddr_o),
    .lsu_exc_valid_o  (lsu_exc_valid_o),
    .lsu_exc_cause_o  (lsu_exc_cause_o),
    .lsu_exc_tval_o   (lsu_exc_tval_o),
    .mem_req_o        (mem_req_o),
    .mem_addr_o       (mem_addr_o),
    .mem_ack_i        (mem_ack_i),
    .mem_rdata_i      (mem_rdata_i),
    .en_translation_i (en_translation_i),
    .priv_user_i      (priv_user_i),
    .sum_i            (sum_i),
    .mxr_i            (mxr_i),
    .satp_ppn_i       (satp_ppn_i),
    .flush_tlb_i      (flush_tlb_i)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  // ------------------------------
  // pte memory, four-phase slave
  // ------------------------------
  initial begin : mem_slave
    int unsigned wait_cnt;
    mem_ack_i   = 1'b0;
    mem_rdata_i = '0;
    wait_cnt    = 0;
    forever begin
      @(negedge clk);
      if (mem_req_o && !mem_ack_i) begin
        // random latency per transaction
        if (wait_cnt >= mem_delay) begin
          mem_rdata_i = read_pte(mem_addr_o);
          mem_ack_i   = 1'b1;
          wait_cnt    = 0;
        end else begin
          wait_cnt++;
        end
      end else if (!mem_req_o && mem_ack_i) begin
        mem_ack_i = 1'b0;
      end
    end
  end

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic mmu_pkg::pte_t read_pte(input mmu_pkg::paddr_t a);
    if (pt_mem.exists(a)) return pt_mem[a];
    return '0;
  endfunction

  function automatic mmu_pkg::pte_t make_pte(input mmu_pkg::ppn_t ppn, input logic [9:0] flags);
    mmu_pkg::pte_t p;
    p = '0;
    p[mmu_pkg::PTE_PPN_LSB +: mmu_pkg::PPNW] = ppn;
    p[9:0] = flags;
    return p;
  endfunction

  // entry address is table base plus 8 bytes per vpn index
  function automatic mmu_pkg::paddr_t pte_addr(input mmu_pkg::ppn_t tbl,
                                               input mmu_pkg::vaddr_t va, input int lvl);
    logic [8:0] idx;
    idx = 9'(va >> (12 + 9 * lvl));
    return (mmu_pkg::paddr_t'(tbl) << 12) + (mmu_pkg::paddr_t'(idx) << 3);
  endfunction

  function automatic logic rand_bit();
    return 1'($urandom);
  endfunction

  function automatic mmu_pkg::ppn_t rand_ppn(input int lvl);
    mmu_pkg::ppn_t ppn;
    ppn = mmu_pkg::ppn_t'({$urandom, $urandom});
    // aligned to the page size of the level
    return ppn & ~((mmu_pkg::ppn_t'(1) << (9 * lvl)) - mmu_pkg::ppn_t'(1));
  endfunction

  // each case gets its own root index so no two mappings overlap
  function automatic mmu_pkg::vaddr_t fresh_vaddr();
    mmu_pkg::vaddr_t va;
    va = {next_vpn2, 30'($urandom)};
    next_vpn2 = next_vpn2 + 9'd1;
    return va;
  endfunction

  // builds pointer entries down to lvl, then writes pte there
  task automatic set_pte(input mmu_pkg::vaddr_t va, input int lvl, input mmu_pkg::pte_t pte);
    mmu_pkg::ppn_t   tbl;
    mmu_pkg::paddr_t a;
    mmu_pkg::pte_t   p;
    tbl = satp_ppn_i;
    for (int l = 2; l > lvl; l--) begin
      a = pte_addr(tbl, va, l);
      if (!pt_mem.exists(a)) begin
        pt_mem[a] = make_pte(next_table, F_V);
        next_table = next_table + mmu_pkg::ppn_t'(1);
      end
      p = pt_mem[a];
      tbl = p[mmu_pkg::PTE_PPN_LSB +: mmu_pkg::PPNW];
    end
    pt_mem[pte_addr(tbl, va, lvl)] = pte;
  endtask

  // ------------------------------
  // reference translation model
  // ------------------------------
  function automatic void model_xlate(input mmu_pkg::vaddr_t va, input logic store,
                                      output mmu_pkg::paddr_t pa, output logic fault);
    mmu_pkg::ppn_t   tbl;
    mmu_pkg::pte_t   pte;
    mmu_pkg::ppn_t   ppn;
    mmu_pkg::paddr_t mask;
    logic            leaf;
    pa    = '0;
    fault = 1'b0;
    if (!en_translation_i) begin
      pa = mmu_pkg::paddr_t'(va);
      return;
    end
    tbl = satp_ppn_i;
    for (int lvl = 2; lvl >= 0; lvl--) begin
      pte  = read_pte(pte_addr(tbl, va, lvl));
      ppn  = pte[mmu_pkg::PTE_PPN_LSB +: mmu_pkg::PPNW];
      leaf = pte[mmu_pkg::PTE_R] || pte[mmu_pkg::PTE_X];
      // offset bits covered by one entry at this level
      mask = (mmu_pkg::paddr_t'(1) << (12 + 9 * lvl)) - mmu_pkg::paddr_t'(1);
      if (!pte[mmu_pkg::PTE_V] || (pte[mmu_pkg::PTE_W] && !pte[mmu_pkg::PTE_R])) begin
        fault = 1'b1;
        return;
      end
      if (leaf) begin
        if (!pte[mmu_pkg::PTE_A] || (((mmu_pkg::paddr_t'(ppn) << 12) & mask) != '0)) begin
          fault = 1'b1;
        end else if (priv_user_i ? !pte[mmu_pkg::PTE_U] : (pte[mmu_pkg::PTE_U] && !sum_i)) begin
          fault = 1'b1;
        end else if (store ? !(pte[mmu_pkg::PTE_W] && pte[mmu_pkg::PTE_D])
                           : !(pte[mmu_pkg::PTE_R] || (pte[mmu_pkg::PTE_X] && mxr_i))) begin
          fault = 1'b1;
        end
        pa = ((mmu_pkg::paddr_t'(ppn) << 12) & ~mask) | (mmu_pkg::paddr_t'(va) & mask);
        return;
      end
      if (lvl == 0) begin
        fault = 1'b1;
        return;
      end
      tbl = ppn;
    end
  endfunction

  // ------------------------------
  // lsu side
  // ------------------------------
  task automatic translate(input mmu_pkg::vaddr_t va, input logic store);
    int n;
    int hold;
    mem_delay      = $urandom % 4;
    res_mem        = 1'b0;
    lsu_req_i      = 1'b1;
    lsu_vaddr_i    = va;
    lsu_is_store_i = store;
    n = 0;
    do begin
      @(negedge clk);
      if (mem_req_o) res_mem = 1'b1;
      n++;
    end while (!lsu_ack_o && n < ACK_TIMEOUT);
    if (!lsu_ack_o) begin
      timeouts++;
      $display("no response from the MMU within %0d cycles for vaddr %h", ACK_TIMEOUT, va);
    end
    res_lat   = n;
    res_paddr = lsu_paddr_o;
    res_exc   = lsu_exc_valid_o;
    res_cause = lsu_exc_cause_o;
    res_tval  = lsu_exc_tval_o;
    // back-pressure, the response has to hold
    hold = int'($urandom % 3);
    repeat (hold) begin
      @(negedge clk);
      check_eq("held ack", 64'(1), 64'(lsu_ack_o));
      check_eq("held paddr", 64'(res_paddr), 64'(lsu_paddr_o));
      check_eq("held exc", 64'(res_exc), 64'(lsu_exc_valid_o));
      check_eq("held cause", 64'(res_cause), 64'(lsu_exc_cause_o));
      check_eq("held tval", 64'(res_tval), 64'(lsu_exc_tval_o));
    end
    lsu_req_i = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (lsu_ack_o && n < ACK_TIMEOUT);
    if (lsu_ack_o) begin
      timeouts++;
      $display("ack still high %0d cycles after the request dropped", ACK_TIMEOUT);
    end
  endtask

  task automatic run_case(input string name, input mmu_pkg::vaddr_t va, input logic store);
    mmu_pkg::paddr_t exp_pa;
    logic            exp_fault;
    model_xlate(va, store, exp_pa, exp_fault);
    translate(va, store);
    check_eq({name, " fault"}, 64'(exp_fault), 64'(res_exc));
    if (exp_fault) begin
      check_eq({name, " cause"}, 64'(store ? 4'd15 : 4'd13), 64'(res_cause));
      check_eq({name, " tval"}, 64'(va), 64'(res_tval));
    end else begin
      check_eq({name, " paddr"}, 64'(exp_pa), 64'(res_paddr));
    end
  endtask

  task automatic perm_case(input string name, input logic [9:0] flags, input logic store,
                           input logic user, input logic sum, input logic mxr,
                           input logic exp_fault);
    mmu_pkg::vaddr_t va;
    va = fresh_vaddr();
    set_pte(va, 0, make_pte(rand_ppn(0), flags));
    priv_user_i = user;
    sum_i       = sum;
    mxr_i       = mxr;
    run_case(name, va, store);
    check_eq({name, " expected fault"}, 64'(exp_fault), 64'(res_exc));
  endtask

  task automatic walk_case(input string name, input int lvl, input mmu_pkg::pte_t pte);
    mmu_pkg::vaddr_t va;
    va = fresh_vaddr();
    set_pte(va, lvl, pte);
    run_case(name, va, rand_bit());
    check_eq({name, " expected fault"}, 64'(1), 64'(res_exc));
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin : stimulus
    mmu_pkg::vaddr_t va;
    mmu_pkg::vaddr_t va2;
    mmu_pkg::vaddr_t mask;
    int              lvl;
    void'($urandom(SEED));
    errors           = 0;
    timeouts         = 0;
    rst_n_i          = 1'b0;
    lsu_req_i        = 1'b0;
    lsu_vaddr_i      = '0;
    lsu_is_store_i   = 1'b0;
    en_translation_i = 1'b0;
    priv_user_i      = 1'b0;
    sum_i            = 1'b0;
    mxr_i            = 1'b0;
    satp_ppn_i       = 44'h0_0008_0000;
    flush_tlb_i      = 1'b0;
    next_table       = 44'h0_0008_0001;
    next_vpn2        = 9'd1;
    mem_delay        = 0;
    repeat (2) @(negedge clk);
    rst_n_i = 1'b1;

    // idle outputs, then bare mode
    check_eq("reset ack", 64'(0), 64'(lsu_ack_o));
    check_eq("reset mem req", 64'(0), 64'(mem_req_o));
    repeat (4) begin
      run_case("bare", mmu_pkg::vaddr_t'({$urandom, $urandom}), rand_bit());
      check_eq("bare memory traffic", 64'(0), 64'(res_mem));
      check_eq("bare latency", 64'(HIT_LATENCY), 64'(res_lat));
    end

    // random 4k, 2m and 1g pages, then a hit on the same page
    en_translation_i = 1'b1;
    va = '0;
    repeat (NUM_RANDOM) begin
      va  = fresh_vaddr();
      lvl = int'($urandom % 3);
      set_pte(va, lvl, make_pte(rand_ppn(lvl), F_V | F_A | F_R | F_W | F_D |
                                (rand_bit() ? F_X : 10'd0)));
      run_case("random map", va, rand_bit());
      check_eq("random map walk", 64'(1), 64'(res_mem));
      mask = (mmu_pkg::vaddr_t'(1) << (12 + 9 * lvl)) - mmu_pkg::vaddr_t'(1);
      va2  = (va & ~mask) | (mmu_pkg::vaddr_t'({$urandom, $urandom}) & mask);
      run_case("repeat hit", va2, rand_bit());
      check_eq("repeat hit memory traffic", 64'(0), 64'(res_mem));
      check_eq("repeat hit latency", 64'(HIT_LATENCY), 64'(res_lat));
    end

    // last page is still cached, a flush forces a new walk
    run_case("before flush", va, 1'b0);
    check_eq("before flush memory traffic", 64'(0), 64'(res_mem));
    flush_tlb_i = 1'b1;
    @(negedge clk);
    flush_tlb_i = 1'b0;
    run_case("after flush", va, 1'b0);
    check_eq("after flush walk", 64'(1), 64'(res_mem));

    // leaf permissions
    perm_case("store no W", F_V | F_A | F_R | F_D, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
    perm_case("store no D", F_V | F_A | F_R | F_W, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
    perm_case("user on S page", F_V | F_A | F_R, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
    perm_case("S on U page", F_V | F_A | F_R | F_U, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    perm_case("S on U page sum", F_V | F_A | F_R | F_U, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    perm_case("exec only load", F_V | F_A | F_X, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    perm_case("exec only load mxr", F_V | F_A | F_X, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    priv_user_i = 1'b0;
    sum_i       = 1'b0;
    mxr_i       = 1'b0;

    // walker faults
    walk_case("invalid pte", 1, '0);
    walk_case("W without R", 0, make_pte(rand_ppn(0), F_V | F_A | F_W | F_D));
    walk_case("A clear", 0, make_pte(rand_ppn(0), F_V | F_R));
    walk_case("misaligned megapage", 1,
              make_pte(rand_ppn(1) | mmu_pkg::ppn_t'(1), F_V | F_A | F_R | F_W | F_D));
    walk_case("pointer at level 0", 0, make_pte(rand_ppn(0), F_V));

    $display("failed checks: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mmu_top.sv ====
/*
 * Sv39 data MMU top: control FSM, data TLB, page table walker and leaf checker
 */
`timescale 1ns/10ps
`default_nettype none

module mmu_top (
  input  wire logic          clk_i,
  input  wire logic          rst_n_i,
  // lsu translation request
  input  wire logic          lsu_req_i,
  input  mmu_pkg::vaddr_t    lsu_vaddr_i,
  input  wire logic          lsu_is_store_i,
  output logic               lsu_ack_o,
  output mmu_pkg::paddr_t    lsu_paddr_o,
  output logic               lsu_exc_valid_o,
  output mmu_pkg::cause_t    lsu_exc_cause_o,
  output mmu_pkg::vaddr_t    lsu_exc_tval_o,
  // pte memory port
  output logic               mem_req_o,
  output mmu_pkg::paddr_t    mem_addr_o,
  input  wire logic          mem_ack_i,
  input  mmu_pkg::pte_t      mem_rdata_i,
  // csr state
  input  wire logic          en_translation_i,
  input  wire logic          priv_user_i,
  input  wire logic          sum_i,
  input  wire logic          mxr_i,
  input  mmu_pkg::ppn_t      satp_ppn_i,
  input  wire logic          flush_tlb_i
);

  logic              tlb_hit;
  mmu_pkg::pte_t     tlb_pte;
  mmu_pkg::level_t   tlb_level;
  logic              lookup;
  mmu_pkg::vaddr_t   lookup_vaddr;
  logic              is_store;
  logic              chk_fault;
  mmu_pkg::paddr_t   chk_paddr;

  walk_if       u_walk_if ();
  tlb_refill_if u_refill_if ();

  // ------------------------------
  // control
  // ------------------------------
  mmu_ctrl u_ctrl (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .lsu_req_i        (lsu_req_i),
    .lsu_vaddr_i      (lsu_vaddr_i),
    .lsu_is_store_i   (lsu_is_store_i),
    .en_translation_i (en_translation_i),
    .lsu_ack_o        (lsu_ack_o),
    .lsu_paddr_o      (lsu_paddr_o),
    .lsu_exc_valid_o  (lsu_exc_valid_o),
    .lsu_exc_cause_o  (lsu_exc_cause_o),
    .lsu_exc_tval_o   (lsu_exc_tval_o),
    .tlb_hit_i        (tlb_hit),
    .chk_fault_i      (chk_fault),
    .chk_paddr_i      (chk_paddr),
    .lookup_o         (lookup),
    .lookup_vaddr_o   (lookup_vaddr),
    .is_store_o       (is_store),
    .walk             (u_walk_if.initiator)
  );

  dtlb #(
    .NUM_ENTRIES (mmu_pkg::DTLB_ENTRIES)
  ) u_dtlb (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_tlb_i),
    .lookup_i       (lookup),
    .lookup_vaddr_i (lookup_vaddr),
    .hit_o          (tlb_hit),
    .pte_o          (tlb_pte),
    .level_o        (tlb_level),
    .refill         (u_refill_if.reader)
  );

  ptw u_ptw (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .satp_ppn_i  (satp_ppn_i),
    .mem_req_o   (mem_req_o),
    .mem_addr_o  (mem_addr_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i),
    .walk        (u_walk_if.target),
    .refill      (u_refill_if.writer)
  );

  // checks the registered tlb entry against the latched request
  xlate_check u_check (
    .vaddr_i     (lookup_vaddr),
    .pte_i       (tlb_pte),
    .level_i     (tlb_level),
    .is_store_i  (is_store),
    .priv_user_i (priv_user_i),
    .sum_i       (sum_i),
    .mxr_i       (mxr_i),
    .fault_o     (chk_fault),
    .paddr_o     (chk_paddr)
  );

endmodule

`default_nettype wire

// ==== mmu_ctrl.sv ====
/*
 * translation control FSM: four-phase LSU handshake, TLB lookup sequencing,
 * walk requests and the registered response
 */
`timescale 1ns/10ps
`default_nettype none

module mmu_ctrl (
  input  wire logic          clk_i,
  input  wire logic          rst_n_i,
  input  wire logic          lsu_req_i,
  input  mmu_pkg::vaddr_t    lsu_vaddr_i,
  input  wire logic          lsu_is_store_i,
  input  wire logic          en_translation_i,
  output logic               lsu_ack_o,
  output mmu_pkg::paddr_t    lsu_paddr_o,
  output logic               lsu_exc_valid_o,
  output mmu_pkg::cause_t    lsu_exc_cause_o,
  output mmu_pkg::vaddr_t    lsu_exc_tval_o,
  input  wire logic          tlb_hit_i,
  input  wire logic          chk_fault_i,
  input  mmu_pkg::paddr_t    chk_paddr_i,
  output logic               lookup_o,
  output mmu_pkg::vaddr_t    lookup_vaddr_o,
  output logic               is_store_o,
  walk_if.initiator          walk
);

  mmu_pkg::mmu_state_e  state_q;
  // second lookup cycle, tlb result is valid
  logic                 lkp_wait_q;
  logic                 exc_q;
  mmu_pkg::vaddr_t      vaddr_q;
  logic                 is_store_q;
  mmu_pkg::paddr_t      paddr_q;

  // ------------------------------
  // fsm
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= mmu_pkg::IDLE;
      lkp_wait_q <= 1'b0;
      exc_q      <= 1'b0;
    end else begin
      case (state_q)
        mmu_pkg::IDLE: if (lsu_req_i) begin
          vaddr_q    <= lsu_vaddr_i;
          is_store_q <= lsu_is_store_i;
          lkp_wait_q <= 1'b0;
          state_q    <= mmu_pkg::LOOKUP;
        end
        mmu_pkg::LOOKUP: begin
          lkp_wait_q <= !lkp_wait_q;
          if (lkp_wait_q) begin
            if (!en_translation_i) begin
              // bare mode, low bits pass through
              paddr_q <= mmu_pkg::paddr_t'(vaddr_q);
              exc_q   <= 1'b0;
              state_q <= mmu_pkg::RESPOND;
            end else if (tlb_hit_i) begin
              paddr_q <= chk_paddr_i;
              exc_q   <= chk_fault_i;
              state_q <= mmu_pkg::RESPOND;
            end else begin
              state_q <= mmu_pkg::WALK;
            end
          end
        end
        // after a good refill look up again
        mmu_pkg::WALK: if (walk.walk_ack) begin
          if (walk.walk_fault) begin
            exc_q   <= 1'b1;
            state_q <= mmu_pkg::RESPOND;
          end else begin
            state_q <= mmu_pkg::LOOKUP;
          end
        end
        mmu_pkg::RESPOND: if (!lsu_req_i) state_q <= mmu_pkg::IDLE;
        default: state_q <= mmu_pkg::IDLE;
      endcase
    end
  end

  // ------------------------------
  // outputs
  // ------------------------------
  assign lookup_o        = (state_q == mmu_pkg::LOOKUP) && !lkp_wait_q;
  assign lookup_vaddr_o  = vaddr_q;
  assign is_store_o      = is_store_q;
  assign walk.walk_req   = (state_q == mmu_pkg::WALK);
  assign walk.walk_vaddr = vaddr_q;

  // response held for the whole ack phase
  assign lsu_ack_o       = (state_q == mmu_pkg::RESPOND);
  assign lsu_paddr_o     = paddr_q;
  assign lsu_exc_valid_o = exc_q;
  assign lsu_exc_cause_o = is_store_q ? mmu_pkg::CAUSE_STORE_PAGE_FAULT
                                      : mmu_pkg::CAUSE_LOAD_PAGE_FAULT;
  assign lsu_exc_tval_o  = vaddr_q;

  a_ack_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (lsu_ack_o && lsu_req_i) |=>
      (lsu_ack_o && $stable(lsu_paddr_o) && $stable(lsu_exc_valid_o)));

endmodule

`default_nettype wire

// ==== xlate_check.sv ====
/*
 * leaf permission checks and physical address composition for 4 KiB,
 * 2 MiB and 1 GiB pages
 */
`timescale 1ns/10ps
`default_nettype none

module xlate_check (
  input  mmu_pkg::vaddr_t   vaddr_i,
  input  mmu_pkg::pte_t     pte_i,
  input  mmu_pkg::level_t   level_i,
  input  wire logic         is_store_i,
  input  wire logic         priv_user_i,
  input  wire logic         sum_i,
  input  wire logic         mxr_i,
  output logic              fault_o,
  output mmu_pkg::paddr_t   paddr_o
);

  logic rd_ok;
  logic wr_ok;
  logic priv_ok;

  // ------------------------------
  // permissions
  // ------------------------------
  // store needs W and a dirty page
  assign wr_ok   = pte_i[mmu_pkg::PTE_W] & pte_i[mmu_pkg::PTE_D];
  // mxr makes execute-only pages readable
  assign rd_ok   = pte_i[mmu_pkg::PTE_R] | (pte_i[mmu_pkg::PTE_X] & mxr_i);
  // u mode only on user pages, s mode on user pages only with sum
  assign priv_ok = priv_user_i ? pte_i[mmu_pkg::PTE_U]
                               : (!pte_i[mmu_pkg::PTE_U] || sum_i);

  assign fault_o = !priv_ok || (is_store_i ? !wr_ok : !rd_ok);

  // ------------------------------
  // physical address
  // ------------------------------
  always_comb begin
    paddr_o = {pte_i[mmu_pkg::PTE_PPN_LSB +: mmu_pkg::PPNW],
               vaddr_i[mmu_pkg::PAGE_OFFSET_W-1:0]};
    // megapage and gigapage keep vpn[0] from the vaddr
    if (level_i != 2'd0) begin
      paddr_o[20:12] = vaddr_i[20:12];
    end
    // gigapage also keeps vpn[1]
    if (level_i == 2'd2) begin
      paddr_o[29:21] = vaddr_i[29:21];
    end
  end

endmodule

`default_nettype wire

// ==== ptw.sv ====
/*
 * Sv39 page table walker: reads one PTE per level over a four-phase
 * memory port, checks the entry and refills the data TLB on a valid leaf
 */
`timescale 1ns/10ps
`default_nettype none

module ptw (
  input  wire logic           clk_i,
  input  wire logic           rst_n_i,
  input  mmu_pkg::ppn_t       satp_ppn_i,
  output logic                mem_req_o,
  output mmu_pkg::paddr_t     mem_addr_o,
  input  wire logic           mem_ack_i,
  input  mmu_pkg::pte_t       mem_rdata_i,
  walk_if.target              walk,
  tlb_refill_if.writer        refill
);

  typedef enum logic [1:0] {
    PTW_IDLE,
    PTW_REQ,
    PTW_DRAIN,
    PTW_ACK
  } ptw_state_e;

  ptw_state_e        state_q;
  mmu_pkg::vaddr_t   vaddr_q;
  mmu_pkg::ppn_t     table_q;
  mmu_pkg::level_t   level_q;
  mmu_pkg::pte_t     pte_q;
  logic              fault_q;
  logic              refill_q;

  logic [8:0]        vpn_idx;
  mmu_pkg::ppn_t     pte_ppn;
  logic              is_leaf;
  logic              misaligned;
  logic              pte_fault;

  // ------------------------------
  // pte address and entry decode
  // ------------------------------
  // vpn field of the current level selects the entry
  assign vpn_idx    = vaddr_q[mmu_pkg::PAGE_OFFSET_W + 9*level_q +: 9];
  assign mem_req_o  = (state_q == PTW_REQ);
  // entries are 8 bytes wide
  assign mem_addr_o = {table_q, vpn_idx, 3'b000};

  assign pte_ppn    = pte_q[mmu_pkg::PTE_PPN_LSB +: mmu_pkg::PPNW];
  assign is_leaf    = pte_q[mmu_pkg::PTE_R] | pte_q[mmu_pkg::PTE_X];
  // superpage leaves need zero low ppn fields
  assign misaligned = ((level_q == 2'd2) && (|pte_ppn[17:0])) ||
                      ((level_q == 2'd1) && (|pte_ppn[8:0]));
  assign pte_fault  = !pte_q[mmu_pkg::PTE_V] ||
                      (pte_q[mmu_pkg::PTE_W] && !pte_q[mmu_pkg::PTE_R]) ||
                      (is_leaf && (!pte_q[mmu_pkg::PTE_A] || misaligned)) ||
                      (!is_leaf && (level_q == 2'd0));

  // ------------------------------
  // walk fsm
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= PTW_IDLE;
      fault_q  <= 1'b0;
      refill_q <= 1'b0;
    end else begin
      refill_q <= 1'b0;
      case (state_q)
        PTW_IDLE: if (walk.walk_req) begin
          // start at the root table
          vaddr_q <= walk.walk_vaddr;
          table_q <= satp_ppn_i;
          level_q <= 2'd2;
          fault_q <= 1'b0;
          state_q <= PTW_REQ;
        end
        PTW_REQ: if (mem_ack_i) begin
          pte_q   <= mem_rdata_i;
          state_q <= PTW_DRAIN;
        end
        // req is low here, wait for memory to drop ack
        PTW_DRAIN: if (!mem_ack_i) begin
          if (pte_fault) begin
            fault_q <= 1'b1;
            state_q <= PTW_ACK;
          end else if (is_leaf) begin
            refill_q <= 1'b1;
            state_q  <= PTW_ACK;
          end else begin
            table_q <= pte_ppn;
            level_q <= level_q - 2'd1;
            state_q <= PTW_REQ;
          end
        end
        PTW_ACK: if (!walk.walk_req) state_q <= PTW_IDLE;
        default: state_q <= PTW_IDLE;
      endcase
    end
  end

  // refill pulse lines up with the first ack cycle
  assign walk.walk_ack       = (state_q == PTW_ACK);
  assign walk.walk_fault     = fault_q;
  assign refill.refill_valid = refill_q;
  assign refill.refill_vpn   = vaddr_q[mmu_pkg::VLEN-1:mmu_pkg::PAGE_OFFSET_W];
  assign refill.refill_pte   = pte_q;
  assign refill.refill_level = level_q;

  a_mem_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_req_o && !mem_ack_i) |=> (mem_req_o && $stable(mem_addr_o)));

endmodule

`default_nettype wire

// ==== dtlb.sv ====
/*
 * fully associative data TLB with level-masked match, registered lookup,
 * round-robin refill and whole-TLB flush
 */
`timescale 1ns/10ps
`default_nettype none

module dtlb #(
  parameter int unsigned NUM_ENTRIES = mmu_pkg::DTLB_ENTRIES
) (
  input  wire logic             clk_i,
  input  wire logic             rst_n_i,
  input  wire logic             flush_i,
  input  wire logic             lookup_i,
  input  mmu_pkg::vaddr_t       lookup_vaddr_i,
  output logic                  hit_o,
  output mmu_pkg::pte_t         pte_o,
  output mmu_pkg::level_t       level_o,
  tlb_refill_if.reader          refill
);

  localparam int unsigned IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

  // entry storage
  logic [NUM_ENTRIES-1:0]  valid_q;
  mmu_pkg::vpn_t           tag_q   [NUM_ENTRIES];
  mmu_pkg::pte_t           data_q  [NUM_ENTRIES];
  mmu_pkg::level_t         lvl_q   [NUM_ENTRIES];
  logic [IDX_W-1:0]        rr_q;

  mmu_pkg::vpn_t           lu_vpn;
  logic [NUM_ENTRIES-1:0]  match;
  mmu_pkg::pte_t           sel_pte;
  mmu_pkg::level_t         sel_lvl;

  assign lu_vpn = lookup_vaddr_i[mmu_pkg::VLEN-1:mmu_pkg::PAGE_OFFSET_W];

  // ------------------------------
  // match, masked by page level
  // ------------------------------
  always_comb begin
    sel_pte = '0;
    sel_lvl = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      // vpn[2] always compared, lower fields only for smaller pages
      match[i] = valid_q[i] && (tag_q[i][26:18] == lu_vpn[26:18]) &&
                 ((lvl_q[i] == 2'd2) || (tag_q[i][17:9] == lu_vpn[17:9])) &&
                 ((lvl_q[i] != 2'd0) || (tag_q[i][8:0] == lu_vpn[8:0]));
      if (match[i]) begin
        sel_pte = data_q[i];
        sel_lvl = lvl_q[i];
      end
    end
  end

  // registered lookup result, held while lookup_i is low
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      hit_o <= 1'b0;
    end else if (lookup_i) begin
      hit_o   <= |match;
      pte_o   <= sel_pte;
      level_o <= sel_lvl;
    end
  end

  // ------------------------------
  // refill and flush
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
      rr_q    <= '0;
    end else if (flush_i) begin
      // flush wins over a refill in the same cycle
      valid_q <= '0;
    end else if (refill.refill_valid) begin
      valid_q[rr_q] <= 1'b1;
      tag_q[rr_q]   <= refill.refill_vpn;
      data_q[rr_q]  <= refill.refill_pte;
      lvl_q[rr_q]   <= refill.refill_level;
      rr_q <= (rr_q == IDX_W'(NUM_ENTRIES - 1)) ? '0 : rr_q + 1'b1;
    end
  end

  // refill only follows a miss, so a second matching entry means a stale copy
  a_single_hit : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lookup_i |-> $onehot0(match));

endmodule

`default_nettype wire

// ==== mmu_ifs.sv ====
/*
 * walk_if between control and walker, tlb_refill_if between walker and TLB
 */
`timescale 1ns/10ps
`default_nettype none

// ------------------------------
// walk request, four-phase
// ------------------------------
interface walk_if;
  // held high by the control fsm until ack is seen
  logic                walk_req;
  mmu_pkg::vaddr_t     walk_vaddr;
  // raised by the walker, with fault set on a failed walk
  logic                walk_ack;
  logic                walk_fault;

  modport initiator (
    output walk_req,
    output walk_vaddr,
    input  walk_ack,
    input  walk_fault
  );

  modport target (
    input  walk_req,
    input  walk_vaddr,
    output walk_ack,
    output walk_fault
  );
endinterface

// ------------------------------
// tlb refill, single-cycle pulse
// ------------------------------
interface tlb_refill_if;
  logic                refill_valid;
  mmu_pkg::vpn_t       refill_vpn;
  mmu_pkg::pte_t       refill_pte;
  mmu_pkg::level_t     refill_level;

  modport writer (
    output refill_valid,
    output refill_vpn,
    output refill_pte,
    output refill_level
  );

  modport reader (
    input  refill_valid,
    input  refill_vpn,
    input  refill_pte,
    input  refill_level
  );
endinterface

`default_nettype wire

// ==== mmu_pkg.sv ====
/*
 * Sv39 data MMU shared definitions: widths, typedefs, fault causes,
 * PTE flag positions and the translation control state encoding
 */
`default_nettype none

package mmu_pkg;

  // ------------------------------
  // Sv39 geometry
  // ------------------------------
  localparam int unsigned VLEN          = 39;
  localparam int unsigned PLEN          = 56;
  localparam int unsigned PPNW          = 44;
  // three 9-bit vpn fields
  localparam int unsigned VPNW          = 27;
  localparam int unsigned LEVELS        = 3;
  localparam int unsigned PAGE_OFFSET_W = 12;

  // default data tlb depth
  localparam int unsigned DTLB_ENTRIES  = 4;

  typedef logic [VLEN-1:0] vaddr_t;
  typedef logic [PLEN-1:0] paddr_t;
  typedef logic [PPNW-1:0] ppn_t;
  typedef logic [VPNW-1:0] vpn_t;
  typedef logic [63:0]     pte_t;
  // 2 is a gigapage, 1 a megapage, 0 a 4 KiB page
  typedef logic [1:0]      level_t;
  typedef logic [3:0]      cause_t;

  // ------------------------------
  // exception causes
  // ------------------------------
  localparam cause_t CAUSE_LOAD_PAGE_FAULT  = 4'd13;
  localparam cause_t CAUSE_STORE_PAGE_FAULT = 4'd15;

  // ------------------------------
  // pte layout
  // ------------------------------
  localparam int unsigned PTE_V       = 0;
  localparam int unsigned PTE_R       = 1;
  localparam int unsigned PTE_W       = 2;
  localparam int unsigned PTE_X       = 3;
  localparam int unsigned PTE_U       = 4;
  localparam int unsigned PTE_A       = 6;
  localparam int unsigned PTE_D       = 7;
  // ppn sits in bits 53:10
  localparam int unsigned PTE_PPN_LSB = 10;

  // translation control fsm
  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    WALK,
    RESPOND
  } mmu_state_e;

endpackage

`default_nettype wire
